//--- bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// data memory geometry
`define BUS_DM_ADDR_WIDTH 10 // byte address bits, 1 KiB

// data memory window, inclusive on both ends
`define BUS_DM_LOW  32'h0000_0000
`define BUS_DM_HIGH 32'h0000_03ff

// control register window
`define BUS_CR_LOW   32'h0000_4000 // base of the register block
`define BUS_CR_COUNT 4             // word count, last one is the write counter

`endif

//--- bus_pkg.sv
package bus_pkg;

    // byte count carried on read_size / write_size
    typedef enum logic [2:0] {
        size_none = 3'd0, // no access
        size_byte = 3'd1,
        size_half = 3'd2,
        size_word = 3'd4
    } access_size_t;

    // last master served by the arbiter
    typedef enum logic {
        master_lsu = 1'b0, // load/store port
        master_dbg = 1'b1  // debug / dma port
    } master_t;

endpackage

//--- bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    // master 0, load/store port
    input  logic                  m0_req,
    input  logic [31:0]           m0_address,
    input  logic [31:0]           m0_data_in,
    input  bus_pkg::access_size_t m0_read_size,
    input  bus_pkg::access_size_t m0_write_size,
    output logic                  m0_grant,
    output logic                  m0_accepted,
    output logic [31:0]           m0_data_out,
    // master 1, debug/dma port
    input  logic                  m1_req,
    input  logic [31:0]           m1_address,
    input  logic [31:0]           m1_data_in,
    input  bus_pkg::access_size_t m1_read_size,
    input  bus_pkg::access_size_t m1_write_size,
    output logic                  m1_grant,
    output logic                  m1_accepted,
    output logic [31:0]           m1_data_out,
    // shared bus toward the slaves
    output logic [31:0]           bus_address,
    output logic [31:0]           bus_data_in,
    output bus_pkg::access_size_t bus_read_size,
    output bus_pkg::access_size_t bus_write_size,
    // slave returns
    input  logic                  dm_accepted,
    input  logic [31:0]           dm_data_out,
    input  logic                  cr_accepted,
    input  logic [31:0]           cr_data_out
);

    bus_pkg::master_t last_served;
    logic             any_accepted;
    logic [31:0]      read_data;

    // on a conflict the master not served last wins
    assign m0_grant = m0_req & (~m1_req | (last_served == bus_pkg::master_dbg));
    assign m1_grant = m1_req & (~m0_req | (last_served == bus_pkg::master_lsu));

    always_ff @(posedge clk) begin
        if (reset) begin
            last_served <= bus_pkg::master_dbg; // lsu goes first after reset
        end else if (m0_grant) begin
            last_served <= bus_pkg::master_lsu;
        end else if (m1_grant) begin
            last_served <= bus_pkg::master_dbg;
        end
    end

    always_comb begin
        bus_address    = '0;
        bus_data_in    = '0;
        bus_read_size  = bus_pkg::size_none; // idle bus selects no slave
        bus_write_size = bus_pkg::size_none;
        if (m0_grant) begin
            bus_address    = m0_address;
            bus_data_in    = m0_data_in;
            bus_read_size  = m0_read_size;
            bus_write_size = m0_write_size;
        end else if (m1_grant) begin
            bus_address    = m1_address;
            bus_data_in    = m1_data_in;
            bus_read_size  = m1_read_size;
            bus_write_size = m1_write_size;
        end
    end

    // slaves return zero when not selected, so a plain or merges them
    assign any_accepted = dm_accepted | cr_accepted;
    assign read_data    = dm_data_out | cr_data_out;

    assign m0_accepted = m0_grant & any_accepted;
    assign m1_accepted = m1_grant & any_accepted;
    assign m0_data_out = m0_grant ? read_data : '0;
    assign m1_data_out = m1_grant ? read_data : '0;

endmodule

//--- data_memory.sv
`timescale 1ns/100ps
`include "bus_cfg.svh"

module data_memory (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           address,
    input  logic [31:0]           data_in,
    input  bus_pkg::access_size_t read_size,
    input  bus_pkg::access_size_t write_size,
    output logic                  accepted,
    output logic [31:0]           data_out,
    output logic                  trace_valid,
    output logic [31:0]           trace_word
);

    localparam int AW       = `BUS_DM_ADDR_WIDTH;
    localparam int DM_DEPTH = 2 ** AW;

    logic [7:0]    mem [DM_DEPTH];

    logic          in_window;
    logic [31:0]   offset;        // address relative to window base
    logic [AW-1:0] real_address;
    logic [AW-3:0] word_addr;
    logic [1:0]    byte_offset;
    logic          is_read;
    logic          is_write;
    logic [2:0]    size;
    logic          aligned;
    logic [31:0]   read_word;
    logic [31:0]   shifted_data;  // write bytes moved into their lanes
    logic [3:0]    size_mask;
    logic [3:0]    byte_mask;
    logic [31:0]   merged_word;

    assign in_window    = (address >= `BUS_DM_LOW) && (address <= `BUS_DM_HIGH);
    assign offset       = address - `BUS_DM_LOW;
    assign real_address = offset[AW-1:0];
    assign word_addr    = real_address[AW-1:2];
    assign byte_offset  = real_address[1:0];

    assign is_read  = (read_size != bus_pkg::size_none);
    assign is_write = (write_size != bus_pkg::size_none);
    assign size     = read_size | write_size; // only one side is nonzero when legal

    // size legality and alignment in one place
    always_comb begin
        case (size)
            3'd1:    aligned = 1'b1;
            3'd2:    aligned = (byte_offset[0] == 1'b0);
            3'd4:    aligned = (byte_offset == 2'b00);
            default: aligned = 1'b0; // covers 0, 3 and the rest
        endcase
    end

    assign accepted = in_window & (is_read ^ is_write) & aligned;

    // reads always return the whole aligned word
    assign read_word = {
        mem[{word_addr, 2'b11}],
        mem[{word_addr, 2'b10}],
        mem[{word_addr, 2'b01}],
        mem[{word_addr, 2'b00}]
    };
    assign data_out = (accepted && is_read) ? read_word : '0;

    always_comb begin
        case (write_size)
            bus_pkg::size_byte: size_mask = 4'b0001;
            bus_pkg::size_half: size_mask = 4'b0011;
            bus_pkg::size_word: size_mask = 4'b1111;
            default:            size_mask = 4'b0000;
        endcase
    end

    assign byte_mask    = 4'(size_mask << byte_offset);
    assign shifted_data = data_in << {byte_offset, 3'b000}; // little endian placement

    // new bytes over the old word, lane by lane
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged_word[8*i +: 8] = byte_mask[i] ? shifted_data[8*i +: 8]
                                                 : read_word[8*i +: 8];
        end
    end

    assign trace_valid = accepted & is_write;
    assign trace_word  = trace_valid ? merged_word : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < DM_DEPTH; k++) begin
                mem[k] <= 8'h00; // every byte, the top one too
            end
        end else if (trace_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_mask[i]) begin
                    mem[{word_addr, 2'(i)}] <= merged_word[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- ctrl_registers.sv
`timescale 1ns/100ps
`include "bus_cfg.svh"

module ctrl_registers (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           address,
    input  logic [31:0]           data_in,
    input  bus_pkg::access_size_t read_size,
    input  bus_pkg::access_size_t write_size,
    output logic                  accepted,
    output logic [31:0]           data_out
);

    localparam int IDX_W       = $clog2(`BUS_CR_COUNT);
    localparam int COUNTER_IDX = `BUS_CR_COUNT - 1; // last word is read-only

    logic [31:0]      scratch [COUNTER_IDX];
    logic [31:0]      write_count;

    logic [31:0]      offset;
    logic             in_window;
    logic             aligned;
    logic             word_read;
    logic             word_write;
    logic [IDX_W-1:0] reg_idx;
    logic [31:0]      read_word;

    // unsigned offset also catches addresses below the base
    assign offset    = address - `BUS_CR_LOW;
    assign in_window = (offset < 32'(4 * `BUS_CR_COUNT));
    assign aligned   = (offset[1:0] == 2'b00);
    assign reg_idx   = offset[IDX_W+1:2];

    // word only, and exactly one direction
    assign word_read  = (read_size == bus_pkg::size_word) &&
                        (write_size == bus_pkg::size_none);
    assign word_write = (write_size == bus_pkg::size_word) &&
                        (read_size == bus_pkg::size_none);

    assign accepted = in_window & aligned & (word_read | word_write);

    always_comb begin
        read_word = write_count;
        if (reg_idx != IDX_W'(COUNTER_IDX)) begin
            read_word = scratch[reg_idx];
        end
    end

    assign data_out = (accepted && word_read) ? read_word : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            write_count <= '0;
            for (int i = 0; i < COUNTER_IDX; i++) begin
                scratch[i] <= '0;
            end
        end else if (accepted && word_write) begin
            write_count <= write_count + 32'd1; // counts writes to word 3 as well
            if (reg_idx != IDX_W'(COUNTER_IDX)) begin
                scratch[reg_idx] <= data_in;
            end
        end
    end

endmodule

//--- mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top (
    input  logic                  clk,
    input  logic                  reset,
    // master 0
    input  logic                  m0_req,
    input  logic [31:0]           m0_address,
    input  logic [31:0]           m0_data_in,
    input  bus_pkg::access_size_t m0_read_size,
    input  bus_pkg::access_size_t m0_write_size,
    output logic                  m0_grant,
    output logic                  m0_accepted,
    output logic [31:0]           m0_data_out,
    // master 1
    input  logic                  m1_req,
    input  logic [31:0]           m1_address,
    input  logic [31:0]           m1_data_in,
    input  bus_pkg::access_size_t m1_read_size,
    input  bus_pkg::access_size_t m1_write_size,
    output logic                  m1_grant,
    output logic                  m1_accepted,
    output logic [31:0]           m1_data_out,
    // write trace from the data memory
    output logic                  trace_valid,
    output logic [31:0]           trace_word
);

    logic [31:0]           bus_address;
    logic [31:0]           bus_data_in;
    bus_pkg::access_size_t bus_read_size;
    bus_pkg::access_size_t bus_write_size;
    logic                  dm_accepted;
    logic [31:0]           dm_data_out;
    logic                  cr_accepted;
    logic [31:0]           cr_data_out;

    bus_arbiter u_arbiter (
        .clk, .reset,
        .m0_req, .m0_address, .m0_data_in, .m0_read_size, .m0_write_size,
        .m0_grant, .m0_accepted, .m0_data_out,
        .m1_req, .m1_address, .m1_data_in, .m1_read_size, .m1_write_size,
        .m1_grant, .m1_accepted, .m1_data_out,
        .bus_address, .bus_data_in, .bus_read_size, .bus_write_size,
        .dm_accepted, .dm_data_out, .cr_accepted, .cr_data_out
    );

    data_memory u_data_memory (
        .clk,
        .reset,
        .address     (bus_address),
        .data_in     (bus_data_in),
        .read_size   (bus_read_size),
        .write_size  (bus_write_size),
        .accepted    (dm_accepted),
        .data_out    (dm_data_out),
        .trace_valid (trace_valid),
        .trace_word  (trace_word)
    );

    ctrl_registers u_ctrl_registers (
        .clk,
        .reset,
        .address    (bus_address),
        .data_in    (bus_data_in),
        .read_size  (bus_read_size),
        .write_size (bus_write_size),
        .accepted   (cr_accepted),
        .data_out   (cr_data_out)
    );

endmodule

//--- mem_subsystem_props.sv
`timescale 1ns/100ps

module mem_subsystem_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  m0_req,
    input logic                  m0_grant,
    input logic                  m0_accepted,
    input logic [31:0]           m0_address,
    input bus_pkg::access_size_t m0_read_size,
    input bus_pkg::access_size_t m0_write_size,
    input logic                  m1_req,
    input logic                  m1_grant,
    input logic                  m1_accepted,
    input logic [31:0]           m1_address,
    input bus_pkg::access_size_t m1_read_size,
    input bus_pkg::access_size_t m1_write_size,
    input logic                  trace_valid
);

    int   violations = 0;
    logic m0_misaligned;
    logic m1_misaligned;
    logic m0_writes;
    logic m1_writes;

    function automatic logic misaligned(input logic [31:0] addr, input logic [2:0] size);
        return ((size == 3'd2) && addr[0]) || ((size == 3'd4) && (addr[1:0] != 2'b00));
    endfunction

    assign m0_misaligned = misaligned(m0_address, m0_read_size | m0_write_size);
    assign m1_misaligned = misaligned(m1_address, m1_read_size | m1_write_size);
    assign m0_writes     = m0_grant && m0_accepted && (m0_write_size != bus_pkg::size_none);
    assign m1_writes     = m1_grant && m1_accepted && (m1_write_size != bus_pkg::size_none);

    assert property (@(posedge clk) disable iff (reset) !(m0_grant && m1_grant))
        else begin
            violations++;
            $error("both masters granted");
        end

    assert property (@(posedge clk) disable iff (reset) m0_grant |-> m0_req)
        else begin
            violations++;
            $error("m0 granted without a request");
        end
    assert property (@(posedge clk) disable iff (reset) m1_grant |-> m1_req)
        else begin
            violations++;
            $error("m1 granted without a request");
        end

    // the loser of a conflict is served in the next cycle
    assert property (@(posedge clk) disable iff (reset) (m0_req && !m0_grant) |=> m0_grant)
        else begin
            violations++;
            $error("m0 request waited too long");
        end
    assert property (@(posedge clk) disable iff (reset) (m1_req && !m1_grant) |=> m1_grant)
        else begin
            violations++;
            $error("m1 request waited too long");
        end

    assert property (@(posedge clk) disable iff (reset) trace_valid |-> (m0_writes || m1_writes))
        else begin
            violations++;
            $error("trace without an accepted write");
        end

    assert property (@(posedge clk) disable iff (reset) m0_misaligned |-> !m0_accepted)
        else begin
            violations++;
            $error("misaligned m0 access accepted");
        end
    assert property (@(posedge clk) disable iff (reset) m1_misaligned |-> !m1_accepted)
        else begin
            violations++;
            $error("misaligned m1 access accepted");
        end

endmodule

//--- tb_mem_subsystem.sv
`timescale 1ns/100ps
`include "bus_cfg.svh"

module tb_mem_subsystem;

    localparam int DM_WORDS = (`BUS_DM_HIGH - `BUS_DM_LOW + 1) / 4;
    localparam int N_SIZED  = 48;
    localparam int N_ROUNDS = 24;
    // transfers per test, in test order
    localparam int XFERS = (DM_WORDS + `BUS_CR_COUNT) + (2 * N_SIZED + DM_WORDS) + 17
                         + 2 * `BUS_CR_COUNT + (2 * N_ROUNDS + 1 + DM_WORDS);
    localparam int WATCHDOG_CYCLES   = 10 + 4 * XFERS + 100 * 5;
    localparam logic [31:0] CHECK_ADDR = `BUS_DM_LOW + 32'h100; // victim word

    logic                  clk;
    logic                  reset;
    logic                  req [2];
    logic [31:0]           address [2];
    logic [31:0]           data_in [2];
    bus_pkg::access_size_t read_size [2];
    bus_pkg::access_size_t write_size [2];
    logic                  grant [2];
    logic                  accepted [2];
    logic [31:0]           data_out [2];
    logic                  trace_valid;
    logic [31:0]           trace_word;

    logic [7:0]  model_mem [DM_WORDS * 4];
    logic [31:0] model_regs [`BUS_CR_COUNT - 1];
    int          reg_writes;
    int          seed;
    int          pass_count;
    int          fail_count;
    int          test_errors;
    string       current_test;
    int          grant_order [$];

    bind mem_subsystem_top mem_subsystem_props u_props (
        .clk, .reset,
        .m0_req, .m0_grant, .m0_accepted, .m0_address, .m0_read_size, .m0_write_size,
        .m1_req, .m1_grant, .m1_accepted, .m1_address, .m1_read_size, .m1_write_size,
        .trace_valid
    );

    mem_subsystem_top UUT (
        .clk, .reset,
        .m0_req(req[0]), .m0_address(address[0]), .m0_data_in(data_in[0]),
        .m0_read_size(read_size[0]), .m0_write_size(write_size[0]),
        .m0_grant(grant[0]), .m0_accepted(accepted[0]), .m0_data_out(data_out[0]),
        .m1_req(req[1]), .m1_address(address[1]), .m1_data_in(data_in[1]),
        .m1_read_size(read_size[1]), .m1_write_size(write_size[1]),
        .m1_grant(grant[1]), .m1_accepted(accepted[1]), .m1_data_out(data_out[1]),
        .trace_valid, .trace_word
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("ERR %s: %s expected %h actual %h", current_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // little-endian byte view of the model
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] off;
        logic [31:0] word;
        word = '0;
        if (addr >= `BUS_CR_LOW && addr < `BUS_CR_LOW + 4 * `BUS_CR_COUNT) begin
            off  = (addr - `BUS_CR_LOW) >> 2;
            word = (off == `BUS_CR_COUNT - 1) ? 32'(reg_writes) : model_regs[off];
        end else begin
            off = (addr - `BUS_DM_LOW) & ~32'd3;
            for (int i = 0; i < 4; i++) begin
                word[8*i +: 8] = model_mem[off + i];
            end
        end
        return word;
    endfunction

    function automatic logic [31:0] merged_word(input logic [31:0] addr,
                                                input logic [31:0] data, input int size);
        logic [31:0] word;
        word = expected_read(addr);
        for (int i = 0; i < size; i++) begin
            word[8 * (int'(addr[1:0]) + i) +: 8] = data[8*i +: 8];
        end
        return word;
    endfunction

    // one request held until granted, results sampled in the grant cycle
    task automatic transfer(input int m, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [2:0] rsize, input logic [2:0] wsize,
                            output logic acc, output logic [31:0] rdata,
                            output logic tvalid, output logic [31:0] tword);
        @(negedge clk);
        req[m]        = 1'b1;
        address[m]    = addr;
        data_in[m]    = wdata;
        read_size[m]  = bus_pkg::access_size_t'(rsize);
        write_size[m] = bus_pkg::access_size_t'(wsize);
        #1;
        while (!grant[m]) begin
            @(negedge clk);
            #1;
        end
        grant_order.push_back(m);
        acc    = accepted[m];
        rdata  = data_out[m];
        tvalid = trace_valid;
        tword  = trace_word;
        @(negedge clk); // write committed at the edge before
        req[m]        = 1'b0;
        read_size[m]  = bus_pkg::size_none;
        write_size[m] = bus_pkg::size_none;
    endtask

    task automatic read_and_check(input int m, input logic [31:0] addr);
        logic        acc;
        logic        tv;
        logic [31:0] rdata;
        logic [31:0] tw;
        logic [31:0] expected;
        expected = expected_read(addr);
        transfer(m, addr, '0, 3'd4, 3'd0, acc, rdata, tv, tw);
        check_value("read accepted", 1, acc);
        check_value($sformatf("read %h", addr), expected, rdata);
    endtask

    task automatic write_and_check(input int m, input logic [31:0] addr,
                                   input logic [31:0] data, input logic [2:0] size);
        logic        acc;
        logic        tv;
        logic [31:0] rdata;
        logic [31:0] tw;
        logic [31:0] expected;
        logic [31:0] off;
        expected = merged_word(addr, data, int'(size));
        transfer(m, addr, data, 3'd0, size, acc, rdata, tv, tw);
        check_value("write accepted", 1, acc);
        check_value("trace valid", 1, tv);
        check_value($sformatf("trace word %h", addr), expected, tw);
        off = addr - `BUS_DM_LOW;
        for (int i = 0; i < int'(size); i++) begin
            model_mem[off + i] = data[8*i +: 8];
        end
    endtask

    // size 1, 2 or 4 at a random legal offset inside the word
    task automatic random_write(input int m, input int word_idx, output logic [31:0] addr);
        logic [31:0] rnd;
        logic [2:0]  size;
        rnd = $random(seed);
        case (rnd[1:0])
            2'd0:    size = 3'd1;
            2'd1:    size = 3'd2;
            default: size = 3'd4;
        endcase
        addr = `BUS_DM_LOW + 32'(4 * word_idx);
        if (size == 3'd1) begin
            addr = addr + 32'(rnd[3:2]);
        end else if (size == 3'd2) begin
            addr = addr + (rnd[3] ? 32'd2 : 32'd0);
        end
        write_and_check(m, addr, $random(seed), size);
    endtask

    task automatic reg_write(input int idx, input logic [31:0] data);
        logic        acc;
        logic        tv;
        logic [31:0] rdata;
        logic [31:0] tw;
        transfer(0, `BUS_CR_LOW + 32'(4 * idx), data, 3'd0, 3'd4, acc, rdata, tv, tw);
        check_value("register write accepted", 1, acc);
        check_value("register trace valid", 0, tv);
        if (idx < `BUS_CR_COUNT - 1) begin
            model_regs[idx] = data;
        end
        reg_writes++;
    endtask

    task automatic reject_case(input string name, input logic [31:0] addr,
                               input logic [2:0] rsize, input logic [2:0] wsize,
                               input logic [31:0] check_addr);
        logic        acc;
        logic        tv;
        logic [31:0] rdata;
        logic [31:0] tw;
        transfer(0, addr, $random(seed), rsize, wsize, acc, rdata, tv, tw);
        check_value({name, " accepted"}, 0, acc);
        check_value({name, " read data"}, 0, rdata);
        check_value({name, " trace valid"}, 0, tv);
        read_and_check(0, check_addr);
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", current_test);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", current_test, test_errors);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] k0;
        logic [31:0] k1;
        seed  = 32'hf8cb_df8b;
        reset = 1'b1;
        for (int m = 0; m < 2; m++) begin
            req[m]        = 1'b0;
            address[m]    = '0;
            data_in[m]    = '0;
            read_size[m]  = bus_pkg::size_none;
            write_size[m] = bus_pkg::size_none;
        end
        foreach (model_mem[i]) model_mem[i] = 8'h00;
        foreach (model_regs[i]) model_regs[i] = '0;
        reg_writes = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test("reset state");
        #1;
        check_value("m0 grant", 0, grant[0]);
        check_value("m1 grant", 0, grant[1]);
        check_value("m0 accepted", 0, accepted[0]);
        check_value("trace valid", 0, trace_valid);
        for (int w = 0; w < DM_WORDS; w++) read_and_check(0, `BUS_DM_LOW + 32'(4 * w));
        for (int r = 0; r < `BUS_CR_COUNT; r++) read_and_check(0, `BUS_CR_LOW + 32'(4 * r));
        finish_test();

        start_test("sized writes");
        for (int n = 0; n < N_SIZED; n++) begin
            k0 = $random(seed);
            random_write(0, int'(k0 % DM_WORDS), addr);
            read_and_check(0, addr & ~32'd3);
        end
        for (int w = 0; w < DM_WORDS; w++) read_and_check(0, `BUS_DM_LOW + 32'(4 * w));
        finish_test();

        start_test("rejection");
        write_and_check(0, CHECK_ADDR, $random(seed), 3'd4);
        reject_case("misaligned half write", CHECK_ADDR + 1, 3'd0, 3'd2, CHECK_ADDR);
        reject_case("misaligned word write", CHECK_ADDR + 2, 3'd0, 3'd4, CHECK_ADDR);
        reject_case("misaligned half read", CHECK_ADDR + 3, 3'd2, 3'd0, CHECK_ADDR);
        reject_case("misaligned word read", CHECK_ADDR + 1, 3'd4, 3'd0, CHECK_ADDR);
        reject_case("size 3 write", CHECK_ADDR, 3'd0, 3'd3, CHECK_ADDR);
        reject_case("read and write", CHECK_ADDR, 3'd4, 3'd4, CHECK_ADDR);
        reject_case("outside windows", 32'h0000_2100, 3'd0, 3'd4, CHECK_ADDR); // aliases victim
        reject_case("register byte write", `BUS_CR_LOW, 3'd0, 3'd1, `BUS_CR_LOW);
        finish_test();

        start_test("registers");
        for (int r = 0; r < `BUS_CR_COUNT; r++) reg_write(r, $random(seed)); // word 3 ignores data
        for (int r = 0; r < `BUS_CR_COUNT; r++) read_and_check(0, `BUS_CR_LOW + 32'(4 * r));
        finish_test();

        start_test("arbitration");
        grant_order.delete();
        for (int r = 0; r < N_ROUNDS; r++) begin
            if (r == N_ROUNDS / 2) begin
                // a lone transfer by the last winner flips who wins the next conflict
                read_and_check(grant_order[grant_order.size() - 2], CHECK_ADDR);
            end
            k0 = $random(seed);
            k1 = $random(seed);
            fork
                random_write(0, 2 * int'(k0 % (DM_WORDS / 2)), a0); // even words
                random_write(1, 2 * int'(k1 % (DM_WORDS / 2)) + 1, a1); // odd words
            join
        end
        check_value("grant count", 2 * N_ROUNDS + 1, grant_order.size());
        for (int i = 1; i < grant_order.size(); i++) begin
            check_value($sformatf("grant %0d owner", i), 1 - grant_order[i-1], grant_order[i]);
        end
        for (int w = 0; w < DM_WORDS; w++) read_and_check(1, `BUS_DM_LOW + 32'(4 * w));
        finish_test();

        if (UUT.u_props.violations != 0) begin
            $display("bus protocol assertions fired %0d times", UUT.u_props.violations);
            fail_count++;
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
bus_pkg.sv
bus_arbiter.sv
data_memory.sv
ctrl_registers.sv
mem_subsystem_top.sv
mem_subsystem_props.sv
tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - .
    files:
      - bus_pkg.sv
      - bus_arbiter.sv
      - data_memory.sv
      - ctrl_registers.sv
      - mem_subsystem_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_subsystem_props.sv
      - tb_mem_subsystem.sv
